// ==== common/rob_pkg.sv ====
// shared widths and depths of the reorder buffer
// packed records for dispatch, completion, commit and queue entries
// wrap-around index helper used by the queues and the dispatch steering

package rob_pkg;

	localparam int arn_width = 5;                        // architectural register number
	localparam int prf_size = 64;                        // physical registers
	localparam int prn_width = $clog2(prf_size);         // physical register number
	localparam int queue_depth = 16;                     // entries per thread queue
	localparam int index_width = $clog2(queue_depth);    // entry index inside one queue

	// ******************************
	// reorder tag whose thread bit 0 selects thread 1
	typedef struct packed {
		logic                   thread;
		logic [index_width-1:0] index;
	} rob_tag_t;

	// one instruction on a dispatch slot
	typedef struct packed {
		logic                 valid;
		logic                 thread;       // 0 for thread 1, 1 for thread 2
		logic [arn_width-1:0] arn_dest;
		logic [prn_width-1:0] prn_dest;
		logic                 is_branch;
	} dispatch_inst_t;

	// one function unit reporting a finished instruction
	typedef struct packed {
		logic     valid;
		rob_tag_t tag;
	} complete_t;

	// one retiring instruction, sent on to the retirement RAT
	typedef struct packed {
		logic                 valid;
		logic [arn_width-1:0] arn_dest;
		logic [prn_width-1:0] prn_dest;
		logic                 is_branch;
	} commit_t;

	// payload held in a queue entry
	typedef struct packed {
		logic [arn_width-1:0] arn_dest;
		logic [prn_width-1:0] prn_dest;
		logic                 is_branch;
	} entry_t;

	// ******************************
	// advance an entry index by 0..2 and wrap at queue_depth
	function automatic logic [index_width-1:0] index_add(
		input logic [index_width-1:0] index,
		input logic [1:0]             step
	);
		logic [index_width:0] sum;
		sum = index + step;
		if (sum >= queue_depth)
			sum = sum - (index_width+1)'(queue_depth);  // past the last entry
		return sum[index_width-1:0];
	endfunction

endpackage

// ==== rob/thread_queue.sv ====
// circular entry array for one thread of the reorder buffer
// binary head, tail and occupancy count, wrapping at queue_depth
// per-entry occupied and executed bits, views of the two oldest entries

`timescale 1ns/100ps

module thread_queue
	import rob_pkg::*;
#(
	parameter logic thread_id = 1'b0,                    // tag thread bit owned by this queue
	parameter int num_fu = 6
)
(
	input  logic                   clock,
	input  logic                   reset,
	input  logic                   push1_valid,          // first push, lands at tail
	input  logic                   push2_valid,          // second push, lands at tail + 1
	input  entry_t                 push1_entry,
	input  entry_t                 push2_entry,
	input  complete_t [num_fu-1:0] complete,
	input  logic [1:0]             pop_count,            // entries retired at this edge
	output logic [index_width-1:0] tail_index,
	output logic [index_width:0]   free_count,
	output logic [1:0]             head_valid,           // bit 0 is the oldest entry
	output logic [1:0]             head_executed,
	output entry_t [1:0]           head_entries
);

	entry_t                 entries [queue_depth];       // payload only, never reset
	logic [queue_depth-1:0] occupied;
	logic [queue_depth-1:0] executed;
	logic [index_width-1:0] head;
	logic [index_width-1:0] tail;
	logic [index_width:0]   count;                       // 0 .. queue_depth
	logic [index_width-1:0] head_next;                   // second oldest slot
	logic [index_width-1:0] tail_next;                   // slot for the second push
	logic [1:0]             push_total;

	assign head_next = index_add(head, 2'd1);
	assign tail_next = index_add(tail, 2'd1);
	assign push_total = {1'b0, push1_valid} + {1'b0, push2_valid};

	// ******************************
	// status seen by steering and commit

	assign tail_index = tail;
	assign free_count = (index_width+1)'(queue_depth) - count;

	assign head_valid = {occupied[head_next], occupied[head]};
	assign head_executed = {executed[head_next], executed[head]};
	assign head_entries[0] = entries[head];
	assign head_entries[1] = entries[head_next];

	// ******************************
	// payload writes at the tail
	always_ff @(posedge clock)
	begin
		if (push1_valid)
			entries[tail] <= push1_entry;
		if (push2_valid)
			entries[tail_next] <= push2_entry;
	end

	// control state
	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			occupied <= '0;
			executed <= '0;
			head <= '0;
			tail <= '0;
			count <= '0;
		end
		else
		begin
			// completions addressed to this thread mark their entry done
			for (int f = 0; f < num_fu; f++)
			begin
				if (complete[f].valid && complete[f].tag.thread == thread_id)
					executed[complete[f].tag.index] <= 1'b1;
			end

			// retire from the head
			if (pop_count != 2'd0)
			begin
				occupied[head] <= 1'b0;
				executed[head] <= 1'b0;
			end
			if (pop_count == 2'd2)
			begin
				occupied[head_next] <= 1'b0;
				executed[head_next] <= 1'b0;
			end

			// new entries start not executed
			if (push1_valid)
			begin
				occupied[tail] <= 1'b1;
				executed[tail] <= 1'b0;
			end
			if (push2_valid)
			begin
				occupied[tail_next] <= 1'b1;
				executed[tail_next] <= 1'b0;
			end

			head <= index_add(head, pop_count);
			tail <= index_add(tail, push_total);
			count <= count + push_total - pop_count;  // push and pop may overlap
		end
	end

endmodule

// ==== rob/dispatch_steer.sv ====
// dispatch steering for the two thread queues
// sorts the slot pair by thread, fills each queue's push ports in order,
// computes dispatch ready from free space and forms the returned tags

`timescale 1ns/100ps

module dispatch_steer
	import rob_pkg::*;
(
	input  dispatch_inst_t         dispatch_slot1,
	input  dispatch_inst_t         dispatch_slot2,
	input  logic [index_width:0]   free_count_t1,
	input  logic [index_width:0]   free_count_t2,
	input  logic [index_width-1:0] tail_index_t1,
	input  logic [index_width-1:0] tail_index_t2,
	output logic                   dispatch_ready,
	output logic                   push1_valid_t1,
	output logic                   push2_valid_t1,
	output entry_t                 push1_entry_t1,
	output entry_t                 push2_entry_t1,
	output logic                   push1_valid_t2,
	output logic                   push2_valid_t2,
	output entry_t                 push1_entry_t2,
	output entry_t                 push2_entry_t2,
	output rob_tag_t               tag_slot1,
	output rob_tag_t               tag_slot2
);

	logic       valid1;
	logic       valid2;
	logic [1:0] need_t1;                                 // valid slots aimed at thread 1
	logic [1:0] need_t2;
	logic       first_t1;                                // pushes before the ready gate
	logic       second_t1;
	logic       first_t2;
	logic       second_t2;

	// strip the dispatch record down to the stored payload
	function automatic entry_t payload(input dispatch_inst_t inst);
		entry_t e;
		e.arn_dest = inst.arn_dest;
		e.prn_dest = inst.prn_dest;
		e.is_branch = inst.is_branch;
		return e;
	endfunction

	assign valid1 = dispatch_slot1.valid;
	assign valid2 = dispatch_slot2.valid;

	assign need_t1 = {1'b0, valid1 & ~dispatch_slot1.thread} +
		{1'b0, valid2 & ~dispatch_slot2.thread};
	assign need_t2 = {1'b0, valid1 & dispatch_slot1.thread} +
		{1'b0, valid2 & dispatch_slot2.thread};

	// registered free counts only, so same-cycle commits never loop back here
	assign dispatch_ready = (free_count_t1 >= need_t1) && (free_count_t2 >= need_t2);

	always_comb
	begin
		first_t1 = 1'b0;
		second_t1 = 1'b0;
		first_t2 = 1'b0;
		second_t2 = 1'b0;
		push1_entry_t1 = payload(dispatch_slot1);
		push2_entry_t1 = payload(dispatch_slot2);
		push1_entry_t2 = payload(dispatch_slot1);
		push2_entry_t2 = payload(dispatch_slot2);
		tag_slot1 = '0;
		tag_slot2 = '0;

		case ({dispatch_slot1.thread, dispatch_slot2.thread})
			2'b00:                                       // both thread 1
			begin
				first_t1 = valid1 | valid2;
				second_t1 = valid1 & valid2;
				if (!valid1)
					push1_entry_t1 = payload(dispatch_slot2);  // slot 2 alone takes the tail
				tag_slot1 = '{thread: 1'b0, index: tail_index_t1};
				tag_slot2 = '{thread: 1'b0,
					index: valid1 ? index_add(tail_index_t1, 2'd1) : tail_index_t1};
			end
			2'b01:                                       // slot 1 thread 1, slot 2 thread 2
			begin
				first_t1 = valid1;
				first_t2 = valid2;
				push1_entry_t2 = payload(dispatch_slot2);
				tag_slot1 = '{thread: 1'b0, index: tail_index_t1};
				tag_slot2 = '{thread: 1'b1, index: tail_index_t2};
			end
			2'b10:                                       // slot 1 thread 2, slot 2 thread 1
			begin
				first_t1 = valid2;
				first_t2 = valid1;
				push1_entry_t1 = payload(dispatch_slot2);
				tag_slot1 = '{thread: 1'b1, index: tail_index_t2};
				tag_slot2 = '{thread: 1'b0, index: tail_index_t1};
			end
			default:                                     // both thread 2
			begin
				first_t2 = valid1 | valid2;
				second_t2 = valid1 & valid2;
				if (!valid1)
					push1_entry_t2 = payload(dispatch_slot2);
				tag_slot1 = '{thread: 1'b1, index: tail_index_t2};
				tag_slot2 = '{thread: 1'b1,
					index: valid1 ? index_add(tail_index_t2, 2'd1) : tail_index_t2};
			end
		endcase
	end

	// nothing enters a queue unless the whole pair is taken
	assign push1_valid_t1 = first_t1 & dispatch_ready;
	assign push2_valid_t1 = second_t1 & dispatch_ready;
	assign push1_valid_t2 = first_t2 & dispatch_ready;
	assign push2_valid_t2 = second_t2 & dispatch_ready;

endmodule

// ==== rob/commit_select.sv ====
// commit selection across the two thread queues
// measures the executed run at each head (0, 1 or 2 entries)
// and applies the commit-status table, thread 1 first

`timescale 1ns/100ps

module commit_select
	import rob_pkg::*;
(
	input  logic [1:0]   head_valid_t1,
	input  logic [1:0]   head_executed_t1,
	input  entry_t [1:0] head_entries_t1,
	input  logic [1:0]   head_valid_t2,
	input  logic [1:0]   head_executed_t2,
	input  entry_t [1:0] head_entries_t2,
	output commit_t      commit_slot1,
	output commit_t      commit_slot2,
	output logic [1:0]   pop_count_t1,
	output logic [1:0]   pop_count_t2
);

	logic [1:0] run_t1;                                  // executed run at thread 1 head
	logic [1:0] run_t2;

	// consecutive valid and executed entries from the oldest one
	function automatic logic [1:0] run_length(
		input logic [1:0] valid,
		input logic [1:0] executed
	);
		logic [1:0] done;
		done = valid & executed;
		if (!done[0])
			return 2'd0;
		else if (!done[1])
			return 2'd1;
		else
			return 2'd2;
	endfunction

	// queue payload as a valid commit record
	function automatic commit_t retire(input entry_t e);
		commit_t c;
		c.valid = 1'b1;
		c.arn_dest = e.arn_dest;
		c.prn_dest = e.prn_dest;
		c.is_branch = e.is_branch;
		return c;
	endfunction

	assign run_t1 = run_length(head_valid_t1, head_executed_t1);
	assign run_t2 = run_length(head_valid_t2, head_executed_t2);

	// ******************************
	// commit-status table
	always_comb
	begin
		commit_slot1 = '0;                               // unused slots stay all zero
		commit_slot2 = '0;
		pop_count_t1 = 2'd0;
		pop_count_t2 = 2'd0;

		if (run_t1 == 2'd2)
		begin
			// two from thread 1
			commit_slot1 = retire(head_entries_t1[0]);
			commit_slot2 = retire(head_entries_t1[1]);
			pop_count_t1 = 2'd2;
		end
		else if (run_t1 == 2'd1)
		begin
			commit_slot1 = retire(head_entries_t1[0]);
			pop_count_t1 = 2'd1;
			if (run_t2 != 2'd0)
			begin
				commit_slot2 = retire(head_entries_t2[0]);  // thread 2 fills the spare slot
				pop_count_t2 = 2'd1;
			end
		end
		else
		begin
			// thread 1 stalled, thread 2 in order
			if (run_t2 != 2'd0)
			begin
				commit_slot1 = retire(head_entries_t2[0]);
				pop_count_t2 = 2'd1;
			end
			if (run_t2 == 2'd2)
			begin
				commit_slot2 = retire(head_entries_t2[1]);
				pop_count_t2 = 2'd2;
			end
		end
	end

endmodule

// ==== rob/rob_top.sv ====
// reorder buffer for a two-thread, two-wide core
// one entry queue per thread, dispatch steering in front,
// commit selection behind the two queue heads

`timescale 1ns/100ps

module rob_top
	import rob_pkg::*;
#(
	parameter int num_fu = 6                             // completion ports
)
(
	input  logic                        clock,
	input  logic                        reset,
	input  dispatch_inst_t              dispatch_slot1,  // older of the pair
	input  dispatch_inst_t              dispatch_slot2,
	output logic                        dispatch_ready,
	output rob_tag_t                    tag_slot1,
	output rob_tag_t                    tag_slot2,
	input  complete_t [num_fu-1:0]      complete,
	output commit_t                     commit_slot1,
	output commit_t                     commit_slot2
);

	// thread 1 queue wires
	logic                 push1_valid_t1;
	logic                 push2_valid_t1;
	entry_t               push1_entry_t1;
	entry_t               push2_entry_t1;
	logic [index_width-1:0] tail_index_t1;
	logic [index_width:0] free_count_t1;
	logic [1:0]           head_valid_t1;
	logic [1:0]           head_executed_t1;
	entry_t [1:0]         head_entries_t1;
	logic [1:0]           pop_count_t1;

	// thread 2 queue wires
	logic                 push1_valid_t2;
	logic                 push2_valid_t2;
	entry_t               push1_entry_t2;
	entry_t               push2_entry_t2;
	logic [index_width-1:0] tail_index_t2;
	logic [index_width:0] free_count_t2;
	logic [1:0]           head_valid_t2;
	logic [1:0]           head_executed_t2;
	entry_t [1:0]         head_entries_t2;
	logic [1:0]           pop_count_t2;

	// ******************************
	dispatch_steer dispatch_steer_i (
		.dispatch_slot1 (dispatch_slot1),
		.dispatch_slot2 (dispatch_slot2),
		.free_count_t1  (free_count_t1),
		.free_count_t2  (free_count_t2),
		.tail_index_t1  (tail_index_t1),
		.tail_index_t2  (tail_index_t2),
		.dispatch_ready (dispatch_ready),
		.push1_valid_t1 (push1_valid_t1),
		.push2_valid_t1 (push2_valid_t1),
		.push1_entry_t1 (push1_entry_t1),
		.push2_entry_t1 (push2_entry_t1),
		.push1_valid_t2 (push1_valid_t2),
		.push2_valid_t2 (push2_valid_t2),
		.push1_entry_t2 (push1_entry_t2),
		.push2_entry_t2 (push2_entry_t2),
		.tag_slot1      (tag_slot1),
		.tag_slot2      (tag_slot2)
	);

	// thread bit 0 is thread 1
	thread_queue #(.thread_id(1'b0), .num_fu(num_fu)) queue_t1_i (
		.clock         (clock),
		.reset         (reset),
		.push1_valid   (push1_valid_t1),
		.push2_valid   (push2_valid_t1),
		.push1_entry   (push1_entry_t1),
		.push2_entry   (push2_entry_t1),
		.complete      (complete),
		.pop_count     (pop_count_t1),
		.tail_index    (tail_index_t1),
		.free_count    (free_count_t1),
		.head_valid    (head_valid_t1),
		.head_executed (head_executed_t1),
		.head_entries  (head_entries_t1)
	);

	thread_queue #(.thread_id(1'b1), .num_fu(num_fu)) queue_t2_i (
		.clock         (clock),
		.reset         (reset),
		.push1_valid   (push1_valid_t2),
		.push2_valid   (push2_valid_t2),
		.push1_entry   (push1_entry_t2),
		.push2_entry   (push2_entry_t2),
		.complete      (complete),
		.pop_count     (pop_count_t2),
		.tail_index    (tail_index_t2),
		.free_count    (free_count_t2),
		.head_valid    (head_valid_t2),
		.head_executed (head_executed_t2),
		.head_entries  (head_entries_t2)
	);

	commit_select commit_select_i (
		.head_valid_t1    (head_valid_t1),
		.head_executed_t1 (head_executed_t1),
		.head_entries_t1  (head_entries_t1),
		.head_valid_t2    (head_valid_t2),
		.head_executed_t2 (head_executed_t2),
		.head_entries_t2  (head_entries_t2),
		.commit_slot1     (commit_slot1),
		.commit_slot2     (commit_slot2),
		.pop_count_t1     (pop_count_t1),
		.pop_count_t2     (pop_count_t2)
	);

endmodule

// ==== tb/rob_tb.sv ====
// testbench for the two-thread reorder buffer
// random dispatch pairs, out-of-order completions, a back-pressure phase
// in-order reference model per thread, concurrent assertions on every output

`timescale 1ns/100ps

module rob_tb
	import rob_pkg::*;
();

	localparam int num_fu = 6;
	localparam int test_cycles = 1200;                   // cycles with new dispatches
	localparam int bp_start = 500;                       // thread 1 fills, its completions held
	localparam int bp_end = 800;
	localparam int timeout_ns = (16 + test_cycles + 400) * 20;

	// one dispatched instruction as the model sees it
	typedef struct {
		rob_tag_t tag;
		entry_t   e;
		logic     sent;                                  // completion already driven
		logic     done;                                  // executed bit set in the DUT
	} model_entry_t;

	logic                   clock;
	logic                   reset;
	dispatch_inst_t         dispatch_slot1;
	dispatch_inst_t         dispatch_slot2;
	logic                   dispatch_ready;
	rob_tag_t               tag_slot1;
	rob_tag_t               tag_slot2;
	complete_t [num_fu-1:0] complete;
	commit_t                commit_slot1;
	commit_t                commit_slot2;

	integer       seed = 32'hb71e;
	model_entry_t model_q [2][$];                        // index 0 is thread 1, oldest first
	int           accept_cnt [2];                        // accepted per thread, gives tag index
	int           cycle;
	int           mismatches;
	int           failures;
	int           accept_count;
	int           dut_commit_count;
	int           stall_cycles;                          // cycles a valid pair was refused
	logic         model_empty;
	logic         end_check;

	// model predictions for the current cycle
	logic         exp_ready;
	rob_tag_t     exp_tag1;
	rob_tag_t     exp_tag2;
	commit_t      exp_commit1;
	commit_t      exp_commit2;
	logic [1:0]   exp_pop [2];

	always #10 clock = ~clock;                           // 20 ns period

	rob_top #(.num_fu(num_fu)) rob_top_i (
		.clock          (clock),
		.reset          (reset),
		.dispatch_slot1 (dispatch_slot1),
		.dispatch_slot2 (dispatch_slot2),
		.dispatch_ready (dispatch_ready),
		.tag_slot1      (tag_slot1),
		.tag_slot2      (tag_slot2),
		.complete       (complete),
		.commit_slot1   (commit_slot1),
		.commit_slot2   (commit_slot2)
	);

	// ******************************
	function automatic int rand_below(input int n);
		return $unsigned($random(seed)) % n;
	endfunction

	function automatic dispatch_inst_t random_inst(input logic only_t1);
		dispatch_inst_t inst;
		inst.valid = (rand_below(4) != 0);
		inst.thread = only_t1 ? 1'b0 : 1'(rand_below(2));
		inst.arn_dest = arn_width'(rand_below(32));
		inst.prn_dest = prn_width'(rand_below(prf_size));
		inst.is_branch = (rand_below(8) == 0);
		return inst;
	endfunction

	task automatic take_slot(input dispatch_inst_t inst, input rob_tag_t tag);
		model_entry_t m;
		if (inst.valid)
		begin
			m.tag = tag;
			m.e = '{arn_dest: inst.arn_dest, prn_dest: inst.prn_dest, is_branch: inst.is_branch};
			m.sent = 1'b0;
			m.done = 1'b0;
			model_q[inst.thread].push_back(m);
			accept_cnt[inst.thread]++;
			accept_count++;
		end
	endtask

	task automatic mark_done(input rob_tag_t tag);
		int t;
		t = tag.thread;
		for (int i = 0; i < model_q[t].size(); i++)
			if (model_q[t][i].tag == tag)
				model_q[t][i].done = 1'b1;
	endtask

	// random not yet completed entry, scanned from a random start so order is scrambled
	task automatic pick_completion(input logic hold_t1, output complete_t c);
		int   t;
		int   n;
		int   start;
		int   i;
		logic found;
		c = '0;
		found = 1'b0;
		t = hold_t1 ? 1 : rand_below(2);                 // thread 1 starved while held
		n = model_q[t].size();
		start = (n == 0) ? 0 : rand_below(n);
		for (int k = 0; k < n; k++)
		begin
			i = (start + k) % n;
			if (!found && !model_q[t][i].sent)
			begin
				model_q[t][i].sent = 1'b1;
				c.valid = 1'b1;
				c.tag = model_q[t][i].tag;
				found = 1'b1;
			end
		end
	endtask

	task automatic report_mismatch(input string what);
		mismatches++;
		$display("Mismatch at %0t: %s", $time, what);
	endtask

	task automatic report_failure(input string what);
		failures++;
		$display("Error at %0t: %s", $time, what);
	endtask

	// ******************************
	// model update and stimulus, all from pre-edge values
	always @(posedge clock)
	begin : model_step
		dispatch_inst_t         next1;
		dispatch_inst_t         next2;
		complete_t [num_fu-1:0] comp_next;
		logic                   hold_t1;
		int                     run [2];
		int                     need [2];
		if (reset)
		begin
			for (int t = 0; t < 2; t++)
			begin
				model_q[t].delete();
				accept_cnt[t] = 0;
				exp_pop[t] = 2'd0;
			end
			exp_ready = 1'b1;                            // empty queues take anything
			exp_commit1 = '0;
			exp_commit2 = '0;
			cycle = 0;
		end
		else
		begin
			cycle++;
			for (int t = 0; t < 2; t++)                  // commits shown this cycle retire
				for (int k = 0; k < exp_pop[t]; k++)
					void'(model_q[t].pop_front());
			for (int f = 0; f < num_fu; f++)
				if (complete[f].valid)
					mark_done(complete[f].tag);
			if (exp_ready)
			begin
				take_slot(dispatch_slot1, exp_tag1);     // slot 1 is the older one
				take_slot(dispatch_slot2, exp_tag2);
			end
			else if (dispatch_slot1.valid || dispatch_slot2.valid)
				stall_cycles++;

			// next stimulus
			hold_t1 = (cycle >= bp_start && cycle < bp_end);
			if (!exp_ready && (dispatch_slot1.valid || dispatch_slot2.valid))
			begin
				next1 = dispatch_slot1;                  // refused pair is held
				next2 = dispatch_slot2;
			end
			else if (cycle >= test_cycles || rand_below(5) == 0)
			begin
				next1 = '0;
				next2 = '0;
			end
			else
			begin
				next1 = random_inst(hold_t1);
				next2 = random_inst(hold_t1);
			end
			for (int f = 0; f < num_fu; f++)
			begin
				comp_next[f] = '0;
				if (rand_below(3) != 0)
					pick_completion(hold_t1, comp_next[f]);
			end
			dispatch_slot1 <= next1;
			dispatch_slot2 <= next2;
			complete <= comp_next;

			// executed run at each head, then the commit table with thread 1 first
			for (int t = 0; t < 2; t++)
			begin
				run[t] = 0;
				if (model_q[t].size() > 0 && model_q[t][0].done)
					run[t] = 1;
				if (run[t] == 1 && model_q[t].size() > 1 && model_q[t][1].done)
					run[t] = 2;
			end
			exp_commit1 = '0;
			exp_commit2 = '0;
			exp_pop[0] = 2'd0;
			exp_pop[1] = 2'd0;
			if (run[0] == 2)
			begin
				exp_commit1 = commit_t'({1'b1, model_q[0][0].e});
				exp_commit2 = commit_t'({1'b1, model_q[0][1].e});
				exp_pop[0] = 2'd2;
			end
			else if (run[0] == 1)
			begin
				exp_commit1 = commit_t'({1'b1, model_q[0][0].e});
				exp_pop[0] = 2'd1;
				if (run[1] > 0)
				begin
					exp_commit2 = commit_t'({1'b1, model_q[1][0].e});
					exp_pop[1] = 2'd1;
				end
			end
			else if (run[1] > 0)
			begin
				exp_commit1 = commit_t'({1'b1, model_q[1][0].e});
				exp_pop[1] = 2'd1;
				if (run[1] == 2)
				begin
					exp_commit2 = commit_t'({1'b1, model_q[1][1].e});
					exp_pop[1] = 2'd2;
				end
			end

			// free space rule and tags for the pair now driven
			need[0] = 0;
			need[1] = 0;
			if (next1.valid)
				need[next1.thread]++;
			if (next2.valid)
				need[next2.thread]++;
			exp_ready = (queue_depth - model_q[0].size() >= need[0]) &&
				(queue_depth - model_q[1].size() >= need[1]);
			exp_tag1 = '{thread: next1.thread, index: index_width'(accept_cnt[next1.thread])};
			exp_tag2 = '{thread: next2.thread, index: index_width'(accept_cnt[next2.thread] +
				((next1.valid && next1.thread == next2.thread) ? 1 : 0))};
			model_empty = (model_q[0].size() == 0) && (model_q[1].size() == 0) &&
				!next1.valid && !next2.valid;
		end
	end

	// outputs are settled at the falling edge
	always @(negedge clock)
	begin
		if (!reset)
			dut_commit_count += int'(commit_slot1.valid) + int'(commit_slot2.valid);
	end

	// ******************************
	reset_state: assert property (@(posedge clock)
		$fell(reset) |-> !commit_slot1.valid && !commit_slot2.valid && dispatch_ready)
		else report_mismatch("commit valid or dispatch_ready wrong right after reset");

	ready_rule: assert property (@(posedge clock) disable iff (reset) dispatch_ready == exp_ready)
		else report_mismatch($sformatf("dispatch_ready %0b, expected %0b",
			$sampled(dispatch_ready), $sampled(exp_ready)));

	tag1_rule: assert property (@(posedge clock) disable iff (reset)
		dispatch_slot1.valid && exp_ready |-> tag_slot1 == exp_tag1)
		else report_mismatch($sformatf("tag_slot1 %h, expected %h",
			$sampled(tag_slot1), $sampled(exp_tag1)));

	tag2_rule: assert property (@(posedge clock) disable iff (reset)
		dispatch_slot2.valid && exp_ready |-> tag_slot2 == exp_tag2)
		else report_mismatch($sformatf("tag_slot2 %h, expected %h",
			$sampled(tag_slot2), $sampled(exp_tag2)));

	commit1_rule: assert property (@(posedge clock) disable iff (reset)
		commit_slot1 == exp_commit1)
		else report_mismatch($sformatf("commit_slot1 %h, expected %h",
			$sampled(commit_slot1), $sampled(exp_commit1)));

	commit2_rule: assert property (@(posedge clock) disable iff (reset)
		commit_slot2 == exp_commit2)
		else report_mismatch($sformatf("commit_slot2 %h, expected %h",
			$sampled(commit_slot2), $sampled(exp_commit2)));

	slot_order: assert property (@(posedge clock) disable iff (reset)
		commit_slot2.valid |-> commit_slot1.valid)
		else report_mismatch("commit_slot2 valid while commit_slot1 is not");

	no_loss: assert property (@(posedge clock) end_check |-> dut_commit_count == accept_count)
		else report_mismatch($sformatf("%0d commits for %0d accepted instructions",
			$sampled(dut_commit_count), $sampled(accept_count)));

	stall_reached: assert property (@(posedge clock) end_check |-> stall_cycles > 0)
		else report_failure("dispatch was never refused, back-pressure was not exercised");

	// ******************************
	initial
	begin
		clock = 1'b0;
		reset = 1'b1;
		dispatch_slot1 = '0;
		dispatch_slot2 = '0;
		complete = '0;
		mismatches = 0;
		failures = 0;
		accept_count = 0;
		dut_commit_count = 0;
		stall_cycles = 0;
		cycle = 0;
		model_empty = 1'b0;
		end_check = 1'b0;
		repeat (16) @(posedge clock);
		reset <= 1'b0;
		wait (cycle >= test_cycles && model_empty);      // everything dispatched has drained
		@(posedge clock);
		end_check <= 1'b1;
		@(posedge clock);
		@(negedge clock);
		$display("mismatches: %0d, other errors: %0d", mismatches, failures);
		if (mismatches == 0 && failures == 0)
			$display("Result: PASSED");
		else
			$display("Result: FAILED");
		$finish;
	end

	// watchdog
	initial
	begin
		#(timeout_ns);
		$display("timeout after %0d ns, the queues did not drain", timeout_ns);
		$display("Result: FAILED");
		$finish;
	end

endmodule

// ==== files.f ====
common/rob_pkg.sv
rob/thread_queue.sv
rob/dispatch_steer.sv
rob/commit_select.sv
rob/rob_top.sv
tb/rob_tb.sv

// ==== Bender.yml ====
package:
  name: rob

sources:
  - common/rob_pkg.sv
  - rob/thread_queue.sv
  - rob/dispatch_steer.sv
  - rob/commit_select.sv
  - rob/rob_top.sv
  - target: simulation
    files:
      - tb/rob_tb.sv
